// ==== logic/arch_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_map (
  input  logic                                                      clock,
  input  logic                                                      arst_n,
  input  logic                                                      retire_en,
  input  rename_types_pkg::commit_t                                 commit,
  output rename_types_pkg::phys_idx_t [rename_cfg_pkg::num_arch-1:0] arch_state
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_arch; i++) begin
        arch_state[i] <= phys_idx_t'(i); // Identity map out of reset
      end
    end else if (retire_en && commit.has_dest) begin
      arch_state[commit.dest_arch] <= commit.dest_phys;
    end
  end

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        alloc_en,
  input  logic                        free_en,
  input  rename_types_pkg::phys_idx_t free_phys,
  input  logic                        flush,
  output rename_types_pkg::phys_idx_t alloc_phys,
  output logic                        empty
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  phys_idx_t                     slots [num_free];
  logic [$clog2(num_free)-1:0]   head_ptr;
  logic [$clog2(num_free)-1:0]   tail_ptr;
  logic [$clog2(num_free):0]     count;

  assign alloc_phys = slots[head_ptr];
  assign empty      = (count == '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_free; i++) begin
        slots[i] <= phys_idx_t'(num_arch + i); // Upper half starts free
      end
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= ($clog2(num_free)+1)'(num_free);
    end else if (flush) begin
      // Slots between tail and head hold the squashed allocations
      head_ptr <= tail_ptr;
      count    <= ($clog2(num_free)+1)'(num_free);
    end else begin
      if (alloc_en) head_ptr <= head_ptr + 1'b1;
      if (free_en) begin
        slots[tail_ptr] <= free_phys;
        tail_ptr        <= tail_ptr + 1'b1;
      end
      unique case ({alloc_en, free_en})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: ;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clock) disable iff (!arst_n)
    count <= num_free);

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table (
  input  logic                                                      clock,
  input  logic                                                      arst_n,
  input  rename_types_pkg::dispatch_req_t                           req,
  input  logic                                                      alloc_en,
  input  rename_types_pkg::phys_idx_t                               alloc_phys,
  input  rename_types_pkg::phys_idx_t                               complete_phys,
  input  logic                                                      complete_valid,
  input  logic                                                      flush,
  input  rename_types_pkg::phys_idx_t [rename_cfg_pkg::num_arch-1:0] arch_state,
  output rename_types_pkg::phys_idx_t                               src1_phys,
  output rename_types_pkg::phys_idx_t                               src2_phys,
  output logic                                                      src1_ready,
  output logic                                                      src2_ready,
  output rename_types_pkg::phys_idx_t                               stale_phys
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  phys_idx_t [num_arch-1:0] map_q;
  logic      [num_phys-1:0] ready_q; // Scoreboard over all physical regs

  // Sources see the mapping before this dispatch's own write
  assign src1_phys  = map_q[req.src1_arch];
  assign src2_phys  = map_q[req.src2_arch];
  assign src1_ready = ready_q[src1_phys];
  assign src2_ready = ready_q[src2_phys];
  assign stale_phys = map_q[req.dest_arch];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_arch; i++) begin
        map_q[i] <= phys_idx_t'(i);
      end
      ready_q <= '1;
    end else if (flush) begin
      map_q   <= arch_state; // Back to the committed view
      ready_q <= '1;
    end else begin
      if (complete_valid) ready_q[complete_phys] <= 1'b1;
      if (alloc_en) begin
        map_q[req.dest_arch] <= alloc_phys;
        ready_q[alloc_phys]  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_cfg_pkg.sv ====
`default_nettype none

package rename_cfg_pkg;

  // Register file sizes
  localparam int unsigned num_arch = 32;
  localparam int unsigned num_phys = 64;
  localparam int unsigned num_free = num_phys - num_arch; // Regs not backing the arch state

  localparam int unsigned num_rob = 32;

  // Index widths
  localparam int unsigned arch_w = $clog2(num_arch);
  localparam int unsigned phys_w = $clog2(num_phys);
  localparam int unsigned rob_w  = $clog2(num_rob);

endpackage

`default_nettype wire

// ==== logic/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core (
  input  logic                            clock,
  input  logic                            arst_n,
  input  logic                            dispatch_valid,
  input  rename_types_pkg::dispatch_req_t dispatch_req,
  input  rename_types_pkg::complete_t     complete,
  input  logic                            flush,
  output logic                            dispatch_ready,
  output rename_types_pkg::dispatch_rsp_t dispatch_rsp,
  output rename_types_pkg::commit_t       commit
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic                     dispatch_fire;
  logic                     alloc_en;
  logic                     retire_en;
  logic                     free_en;
  logic                     fl_empty;
  logic                     rob_full;
  logic                     src1_ready;
  logic                     src2_ready;
  phys_idx_t                alloc_phys;
  phys_idx_t                src1_phys;
  phys_idx_t                src2_phys;
  phys_idx_t                stale_phys;
  phys_idx_t                complete_phys;
  phys_idx_t [num_arch-1:0] arch_state;
  rob_idx_t                 tail_idx;
  rob_entry_t               rob_head;
  rob_entry_t               new_entry;

  always_comb begin
    new_entry.done       = 1'b0;
    new_entry.has_dest   = dispatch_req.has_dest;
    new_entry.dest_arch  = dispatch_req.dest_arch;
    // Without a destination, point at src1, which is ready by completion time
    new_entry.dest_phys  = dispatch_req.has_dest ? alloc_phys : src1_phys;
    new_entry.stale_phys = stale_phys;
  end

  always_comb begin
    dispatch_rsp.rob_idx    = tail_idx;
    dispatch_rsp.dest_phys  = alloc_phys;
    dispatch_rsp.src1_phys  = src1_phys;
    dispatch_rsp.src1_ready = src1_ready;
    dispatch_rsp.src2_phys  = src2_phys;
    dispatch_rsp.src2_ready = src2_ready;
  end

  always_comb begin
    commit.valid      = retire_en;
    commit.has_dest   = rob_head.has_dest;
    commit.dest_arch  = rob_head.dest_arch;
    commit.dest_phys  = rob_head.dest_phys;
    commit.stale_phys = rob_head.stale_phys;
  end

  rename_ctrl u_rename_ctrl (
    .clock          (clock),
    .arst_n         (arst_n),
    .dispatch_valid (dispatch_valid),
    .has_dest       (dispatch_req.has_dest),
    .flush          (flush),
    .fl_empty       (fl_empty),
    .rob_full       (rob_full),
    .head_done      (rob_head.done),
    .head_has_dest  (rob_head.has_dest),
    .dispatch_ready (dispatch_ready),
    .dispatch_fire  (dispatch_fire),
    .alloc_en       (alloc_en),
    .retire_en      (retire_en),
    .free_en        (free_en)
  );

  free_list u_free_list (
    .clock      (clock),
    .arst_n     (arst_n),
    .alloc_en   (alloc_en),
    .free_en    (free_en),
    .free_phys  (rob_head.stale_phys),
    .flush      (flush),
    .alloc_phys (alloc_phys),
    .empty      (fl_empty)
  );

  map_table u_map_table (
    .clock          (clock),
    .arst_n         (arst_n),
    .req            (dispatch_req),
    .alloc_en       (alloc_en),
    .alloc_phys     (alloc_phys),
    .complete_phys  (complete_phys),
    .complete_valid (complete.valid),
    .flush          (flush),
    .arch_state     (arch_state),
    .src1_phys      (src1_phys),
    .src2_phys      (src2_phys),
    .src1_ready     (src1_ready),
    .src2_ready     (src2_ready),
    .stale_phys     (stale_phys)
  );

  arch_map u_arch_map (
    .clock      (clock),
    .arst_n     (arst_n),
    .retire_en  (retire_en),
    .commit     (commit),
    .arch_state (arch_state)
  );

  reorder_buffer u_reorder_buffer (
    .clock         (clock),
    .arst_n        (arst_n),
    .dispatch_fire (dispatch_fire),
    .new_entry     (new_entry),
    .complete      (complete),
    .retire_en     (retire_en),
    .flush         (flush),
    .tail_idx      (tail_idx),
    .full          (rob_full),
    .head          (rob_head),
    .complete_phys (complete_phys)
  );

endmodule

`default_nettype wire

// ==== logic/rename_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
  input  logic clock,
  input  logic arst_n,
  input  logic dispatch_valid,
  input  logic has_dest,
  input  logic flush,
  input  logic fl_empty,
  input  logic rob_full,
  input  logic head_done,
  input  logic head_has_dest,
  output logic dispatch_ready,
  output logic dispatch_fire,
  output logic alloc_en,
  output logic retire_en,
  output logic free_en
);

  import rename_cfg_pkg::*;

  logic [phys_w-1:0] dest_cnt; // Destinations renamed and not yet retired

  assign dispatch_ready = !rob_full && !(has_dest && fl_empty) && !flush;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign alloc_en       = dispatch_fire && has_dest;
  assign retire_en      = head_done && !flush;
  assign free_en        = retire_en && head_has_dest;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dest_cnt <= '0;
    end else if (flush) begin
      dest_cnt <= '0; // Free list refills on flush
    end else if (alloc_en && !free_en) begin
      dest_cnt <= dest_cnt + 1'b1;
    end else if (free_en && !alloc_en) begin
      dest_cnt <= dest_cnt - 1'b1;
    end
  end

  // Free list occupancy must agree with the in-flight destinations
  a_alloc_nonempty: assert property (@(posedge clock) disable iff (!arst_n)
    alloc_en |-> dest_cnt < num_free);

  // ROB is empty after a flush, so nothing retires in the next cycle
  a_no_retire_flush: assert property (@(posedge clock) disable iff (!arst_n)
    flush |=> !retire_en);

endmodule

`default_nettype wire

// ==== logic/rename_types_pkg.sv ====
`default_nettype none

package rename_types_pkg;

  typedef logic [rename_cfg_pkg::arch_w-1:0] arch_idx_t;
  typedef logic [rename_cfg_pkg::phys_w-1:0] phys_idx_t;
  typedef logic [rename_cfg_pkg::rob_w-1:0]  rob_idx_t;

  typedef struct packed {
    logic      has_dest;
    arch_idx_t dest_arch;
    arch_idx_t src1_arch;
    arch_idx_t src2_arch;
  } dispatch_req_t;

  typedef struct packed {
    rob_idx_t  rob_idx;
    phys_idx_t dest_phys;
    phys_idx_t src1_phys;
    logic      src1_ready;
    phys_idx_t src2_phys;
    logic      src2_ready;
  } dispatch_rsp_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t rob_idx;
  } complete_t;

  typedef struct packed {
    logic      valid;
    logic      has_dest;
    arch_idx_t dest_arch;
    phys_idx_t dest_phys;
    phys_idx_t stale_phys; // Previous mapping, freed on retire
  } commit_t;

  typedef struct packed {
    logic      done;
    logic      has_dest;
    arch_idx_t dest_arch;
    phys_idx_t dest_phys;
    phys_idx_t stale_phys;
  } rob_entry_t;

endpackage

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  logic                         clock,
  input  logic                         arst_n,
  input  logic                         dispatch_fire,
  input  rename_types_pkg::rob_entry_t new_entry,
  input  rename_types_pkg::complete_t  complete,
  input  logic                         retire_en,
  input  logic                         flush,
  output rename_types_pkg::rob_idx_t   tail_idx,
  output logic                         full,
  output rename_types_pkg::rob_entry_t head,
  output rename_types_pkg::phys_idx_t  complete_phys
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  rob_entry_t       entries [num_rob];
  rob_idx_t         head_ptr;
  rob_idx_t         tail_ptr;
  logic [rob_w:0]   count_q;
  rob_idx_t         cpl_off;

  assign tail_idx      = tail_ptr;
  assign full          = (count_q == num_rob);
  assign complete_phys = entries[complete.rob_idx].dest_phys;
  assign cpl_off       = complete.rob_idx - head_ptr; // Age of the completing entry

  always_comb begin
    head      = entries[head_ptr];
    head.done = entries[head_ptr].done && (count_q != '0); // Stale slot when empty
  end

  always_ff @(posedge clock) begin
    if (dispatch_fire) entries[tail_ptr] <= new_entry;
    if (complete.valid && !flush) entries[complete.rob_idx].done <= 1'b1;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count_q  <= '0;
    end else if (flush) begin
      head_ptr <= tail_ptr;
      count_q  <= '0;
    end else begin
      if (dispatch_fire) tail_ptr <= tail_ptr + 1'b1;
      if (retire_en)     head_ptr <= head_ptr + 1'b1;
      unique case ({dispatch_fire, retire_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Completion must target a live entry and arrive only once
  a_complete_live: assert property (@(posedge clock) disable iff (!arst_n)
    complete.valid && !flush |-> ({1'b0, cpl_off} < count_q)
                                 && !entries[complete.rob_idx].done);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, then judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -sv -f verilog.f \
  --top-module tb_rename_core -Mdir obj_dir -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Build or simulation error, see build.log and sim.log"
grep -q "SIMULATION PASSED" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock  = 1'b0;
    arst_n = 1'b0;
    repeat (8) @(posedge clock);
    arst_n <= 1'b1;
  end

  always #2 clock = ~clock; // 4 ns period

endmodule

`default_nettype wire

// ==== verif/tb_rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

  import rename_types_pkg::*;

  logic          clock;
  logic          arst_n;
  logic          dispatch_valid;
  dispatch_req_t dispatch_req;
  complete_t     complete;
  logic          flush;
  logic          dispatch_ready;
  dispatch_rsp_t dispatch_rsp;
  commit_t       commit;

  int seed = 68462;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int spec [32];
  int arch [32];
  bit rdy [64];
  int fl_slots [32];
  int fl_head, fl_tail, fl_count;
  bit m_has_dest [32];
  int m_dest_arch [32];
  int m_dest_phys [32];
  int m_stale [32];
  bit m_done [32];
  int m_head, m_tail, m_count;

  tb_clock_gen u_clock_gen (.clock(clock), .arst_n(arst_n));

  rename_core u_rename_core (
    .clock          (clock),
    .arst_n         (arst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_req   (dispatch_req),
    .complete       (complete),
    .flush          (flush),
    .dispatch_ready (dispatch_ready),
    .dispatch_rsp   (dispatch_rsp),
    .commit         (commit)
  );

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
      spec[i] = i;
      arch[i] = i;
      fl_slots[i] = 32 + i;
    end
    for (int i = 0; i < 64; i++) rdy[i] = 1'b1;
    fl_head = 0;
    fl_tail = 0;
    fl_count = 32;
    m_head = 0;
    m_tail = 0;
    m_count = 0;
  endtask

  task automatic dispatch_one(input bit hd, input int d, input int s1, input int s2,
                              output int idx, output int dest);
    dispatch_req_t r;
    int alloc;
    r.has_dest  = hd;
    r.dest_arch = arch_idx_t'(d);
    r.src1_arch = arch_idx_t'(s1);
    r.src2_arch = arch_idx_t'(s2);
    @(posedge clock);
    dispatch_valid <= 1'b1;
    dispatch_req   <= r;
    @(negedge clock);
    while (!dispatch_ready) @(negedge clock);
    if (m_count >= 32 || (hd && fl_count == 0)) begin
      errors++;
      $display("Dispatch accepted at %0t with a full ROB or an empty free list", $time);
    end
    alloc = fl_slots[fl_head];
    compare("dispatch_rsp.rob_idx", m_tail, dispatch_rsp.rob_idx);
    compare("dispatch_rsp.src1_phys", spec[s1], dispatch_rsp.src1_phys);
    compare("dispatch_rsp.src2_phys", spec[s2], dispatch_rsp.src2_phys);
    compare("dispatch_rsp.src1_ready", rdy[spec[s1]], dispatch_rsp.src1_ready);
    compare("dispatch_rsp.src2_ready", rdy[spec[s2]], dispatch_rsp.src2_ready);
    if (hd) compare("dispatch_rsp.dest_phys", alloc, dispatch_rsp.dest_phys);
    idx = m_tail;
    dest = alloc;
    m_has_dest[m_tail] = hd;
    m_dest_arch[m_tail] = d;
    m_dest_phys[m_tail] = alloc;
    m_stale[m_tail] = spec[d];
    m_done[m_tail] = 1'b0;
    if (hd) begin
      spec[d] = alloc;
      rdy[alloc] = 1'b0;
      fl_head = (fl_head + 1) % 32;
      fl_count--;
    end
    m_tail = (m_tail + 1) % 32;
    m_count++;
    @(posedge clock);
    dispatch_valid <= 1'b0;
  endtask

  task automatic pulse_complete(input int idx);
    complete_t c;
    c.valid   = 1'b1;
    c.rob_idx = rob_idx_t'(idx);
    @(posedge clock);
    complete <= c;
    @(posedge clock);
    complete <= '0;
    m_done[idx] = 1'b1; // Takes effect at this edge
    if (m_has_dest[idx]) rdy[m_dest_phys[idx]] = 1'b1;
  endtask

  // Complete everything in flight in random order, then wait for the ROB to empty
  task automatic drain_rob();
    int pend[$];
    int j;
    int t;
    for (int i = 0; i < m_count; i++) begin
      if (!m_done[(m_head + i) % 32]) pend.push_back((m_head + i) % 32);
    end
    for (int i = pend.size() - 1; i > 0; i--) begin
      j = rand_below(i + 1);
      t = pend[i];
      pend[i] = pend[j];
      pend[j] = t;
    end
    foreach (pend[i]) pulse_complete(pend[i]);
    while (m_count != 0) @(negedge clock);
  endtask

  // Checks each commit half a cycle before its retiring edge
  always @(negedge clock) begin
    if (arst_n) begin
      compare("commit.valid", (m_count > 0) && m_done[m_head] && !flush, commit.valid);
      if (commit.valid && m_count > 0) begin
        compare("commit.has_dest", m_has_dest[m_head], commit.has_dest);
        compare("commit.dest_arch", m_dest_arch[m_head], commit.dest_arch);
        if (m_has_dest[m_head]) begin
          compare("commit.dest_phys", m_dest_phys[m_head], commit.dest_phys);
          compare("commit.stale_phys", m_stale[m_head], commit.stale_phys);
          arch[m_dest_arch[m_head]] = m_dest_phys[m_head];
          fl_slots[fl_tail] = m_stale[m_head];
          fl_tail = (fl_tail + 1) % 32;
          fl_count++;
        end
        m_head = (m_head + 1) % 32;
        m_count--;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= 5000) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic test_reset_order();
    int idx;
    int dest;
    @(negedge clock);
    compare("dispatch_ready", 1, dispatch_ready);
    for (int i = 0; i < 4; i++) begin
      dispatch_one(1'b1, rand_below(32), rand_below(32), rand_below(32), idx, dest);
      compare("rob index order", i, idx);
      compare("allocation order", 32 + i, dest);
    end
    drain_rob();
  endtask

  task automatic test_dependency();
    int w;
    int idx;
    int dest;
    dispatch_one(1'b1, 7, 1, 2, w, dest);
    dispatch_one(1'b1, 9, 7, 3, idx, dest);
    compare("src1_ready after rename", 0, dispatch_rsp.src1_ready);
    pulse_complete(w);
    dispatch_one(1'b1, 10, 7, 7, idx, dest);
    drain_rob();
  endtask

  task automatic test_random_commit();
    int idx;
    int dest;
    for (int i = 0; i < 12; i++) begin
      dispatch_one(rand_below(4) != 0, rand_below(32), rand_below(32), rand_below(32),
                   idx, dest);
    end
    drain_rob();
  endtask

  task automatic test_rob_full();
    int idx;
    int dest;
    int stale;
    int oldest;
    oldest = m_tail;
    for (int i = 0; i < 32; i++) begin
      dispatch_one(1'b1, rand_below(32), rand_below(32), rand_below(32), idx, dest);
    end
    @(posedge clock);
    dispatch_valid <= 1'b1;
    dispatch_req   <= '{has_dest: 1'b1, dest_arch: 5'd4, src1_arch: 5'd5, src2_arch: 5'd6};
    repeat (3) begin
      @(negedge clock);
      compare("dispatch_ready when full", 0, dispatch_ready);
    end
    stale = m_stale[oldest];
    fork
      pulse_complete(oldest);
      dispatch_one(1'b1, 4, 5, 6, idx, dest);
    join
    compare("reused stale_phys", stale, dest);
    drain_rob();
  endtask

  task automatic test_flush();
    int ids [6];
    int dest;
    complete_t c;
    for (int i = 0; i < 6; i++) begin
      dispatch_one(1'b1, rand_below(32), rand_below(32), rand_below(32), ids[i], dest);
    end
    pulse_complete(ids[0]);
    c.valid   = 1'b1;
    c.rob_idx = rob_idx_t'(ids[1]);
    @(posedge clock);
    complete <= c;
    @(posedge clock);
    complete <= '0;
    flush    <= 1'b1;
    m_done[ids[1]] = 1'b1;
    rdy[m_dest_phys[ids[1]]] = 1'b1;
    @(negedge clock);
    compare("commit.valid during flush", 0, commit.valid);
    compare("dispatch_ready during flush", 0, dispatch_ready);
    @(posedge clock);
    flush <= 1'b0;
    for (int i = 0; i < 32; i++) spec[i] = arch[i]; // Model of the flush
    for (int i = 0; i < 64; i++) rdy[i] = 1'b1;
    fl_head = fl_tail;
    fl_count = 32;
    m_head = m_tail;
    m_count = 0;
    for (int i = 0; i < 6; i++) begin
      dispatch_one(1'b1, rand_below(32), rand_below(32), rand_below(32), ids[0], dest);
    end
    drain_rob();
  endtask

  initial begin
    dispatch_valid = 1'b0;
    dispatch_req   = '0;
    complete       = '0;
    flush          = 1'b0;
    model_reset();
    @(posedge arst_n);
    test_reset_order();
    test_dependency();
    test_random_commit();
    test_rob_full();
    test_flush();
    repeat (4) @(posedge clock);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/rename_cfg_pkg.sv
logic/rename_types_pkg.sv
logic/rename_ctrl.sv
logic/free_list.sv
logic/map_table.sv
logic/arch_map.sv
logic/reorder_buffer.sv
logic/rename_core.sv
verif/tb_clock_gen.sv
verif/tb_rename_core.sv
